// File: filelist.f
hw/afifo_cfg_pkg.sv
hw/afifo_ctrl_pkg.sv
hw/asym_width_converter.sv
hw/lane_ram.sv
hw/fifo_ptr_counter.sv
hw/credit_read_fsm.sv
hw/afifo_top.sv
tb/afifo_assertions.sv
tb/afifo_tb.sv

// File: hw/afifo_cfg_pkg.sv
`default_nettype none

package afifo_cfg_pkg;

   // default data format
   localparam int W_DATA_DEF = 8;
   localparam int R_DATA_DEF = 32;
   // address width counted in narrow lanes
   localparam int ADDR_DEF = 6;

   // producer word
   typedef logic [W_DATA_DEF-1:0] narrow_t;
   // consumer word
   typedef logic [R_DATA_DEF-1:0] wide_t;
   // lane-unit address
   typedef logic [ADDR_DEF-1:0] lane_addr_t;
   // fill level, one extra bit so a full FIFO is representable
   typedef logic [ADDR_DEF:0] level_t;

   // wider of the two data widths
   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   // narrower of the two data widths
   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // number of narrow lanes in one wide word
   function automatic int ratio(input int a, input int b);
      return max_w(a, b) / min_w(a, b);
   endfunction

endpackage

`default_nettype wire

// File: hw/afifo_ctrl_pkg.sv
`default_nettype none

package afifo_ctrl_pkg;

   // read side states
   typedef enum logic [1:0] {
      S_IDLE,
      S_STREAM,
      S_FLUSH
   } rd_state_t;

   // consumer credits
   typedef logic [3:0] credit_t;

   // credits granted after reset
   localparam int CREDITS_DEF = 4;

endpackage

`default_nettype wire

// File: hw/afifo_top.sv
`default_nettype none

module afifo_top (
   input  wire                    clk_i,
   input  wire                    rst_n_i,
   // producer side
   input  wire                    w_en_i,
   input  afifo_cfg_pkg::narrow_t w_data_i,
   output logic                   w_full_o,
   // consumer side
   output logic                   rd_valid_o,
   output afifo_cfg_pkg::wide_t   rd_data_o,
   input  wire                    credit_return_i,
   // control and status
   input  wire                    flush_i,
   output afifo_cfg_pkg::level_t  fill_level_o
);

   localparam int W_DATA_W  = afifo_cfg_pkg::W_DATA_DEF;
   localparam int R_DATA_W  = afifo_cfg_pkg::R_DATA_DEF;
   localparam int ADDR_W    = afifo_cfg_pkg::ADDR_DEF;
   localparam int CREDITS   = afifo_ctrl_pkg::CREDITS_DEF;
   localparam int MAXDATA_W = afifo_cfg_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int R         = afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W);
   localparam int MINADDR_W = ADDR_W - $clog2(R);

   logic                     w_en;
   afifo_cfg_pkg::lane_addr_t wr_ptr;
   afifo_cfg_pkg::lane_addr_t rd_ptr;
   logic                     data_avail;
   logic                     rd_issue;
   logic                     ptr_clear;

   logic [R-1:0]             mem_w_en;
   logic [MINADDR_W-1:0]     mem_w_addr;
   logic [MAXDATA_W-1:0]     mem_w_data;
   logic [R-1:0]             mem_r_en;
   logic [MINADDR_W-1:0]     mem_r_addr;
   logic [MAXDATA_W-1:0]     mem_r_data;

   // writes while full are dropped
   assign w_en = w_en_i & ~w_full_o;

   asym_width_converter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_conv (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .w_en_i      (w_en),
      .w_addr_i    (wr_ptr),
      .w_data_i    (w_data_i),
      .r_en_i      (rd_issue),
      .r_addr_i    (rd_ptr),
      .r_data_o    (rd_data_o),
      .mem_w_en_o  (mem_w_en),
      .mem_w_addr_o(mem_w_addr),
      .mem_w_data_o(mem_w_data),
      .mem_r_en_o  (mem_r_en),
      .mem_r_addr_o(mem_r_addr),
      .mem_r_data_i(mem_r_data)
   );

   lane_ram #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_ram (
      .clk_i   (clk_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

   fifo_ptr_counter #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .ADDR_W  (ADDR_W)
   ) u_cnt (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .w_en_i      (w_en),
      .rd_issue_i  (rd_issue),
      .clear_i     (ptr_clear),
      .wr_ptr_o    (wr_ptr),
      .rd_ptr_o    (rd_ptr),
      .level_o     (fill_level_o),
      .data_avail_o(data_avail),
      .w_full_o    (w_full_o)
   );

   credit_read_fsm #(
      .CREDITS(CREDITS)
   ) u_fsm (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .data_avail_i   (data_avail),
      .credit_return_i(credit_return_i),
      .flush_i        (flush_i),
      .rd_issue_o     (rd_issue),
      .rd_valid_o     (rd_valid_o),
      .ptr_clear_o    (ptr_clear)
   );

endmodule

`default_nettype wire

// File: hw/asym_width_converter.sv
`default_nettype none

module asym_width_converter #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  wire                                 clk_i,
   input  wire                                 rst_n_i,
   // user write port, address in lanes
   input  wire                                 w_en_i,
   input  wire [ADDR_W-1:0]                    w_addr_i,
   input  wire [W_DATA_W-1:0]                  w_data_i,
   // user read port, address in lanes
   input  wire                                 r_en_i,
   input  wire [ADDR_W-1:0]                    r_addr_i,
   output logic [R_DATA_W-1:0]                 r_data_o,
   // banked memory write side
   output logic [afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W)-1:0] mem_w_en_o,
   output logic [ADDR_W-$clog2(afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W))-1:0] mem_w_addr_o,
   output logic [afifo_cfg_pkg::max_w(W_DATA_W, R_DATA_W)-1:0] mem_w_data_o,
   // banked memory read side
   output logic [afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W)-1:0] mem_r_en_o,
   output logic [ADDR_W-$clog2(afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W))-1:0] mem_r_addr_o,
   input  wire [afifo_cfg_pkg::max_w(W_DATA_W, R_DATA_W)-1:0] mem_r_data_i
);

   localparam int MAXDATA_W = afifo_cfg_pkg::max_w(W_DATA_W, R_DATA_W);
   localparam int R         = afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W);
   localparam int LSB_W     = $clog2(R);

   logic                 r_valid_q;
   logic [MAXDATA_W-1:0] r_hold_q;
   logic [MAXDATA_W-1:0] r_data_int;

   // memory output is fresh only in the cycle after a read
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_valid_q <= 1'b0;
      end else begin
         r_valid_q <= r_en_i;
      end
   end

   // keep last read word once the RAM output moves on
   always_ff @(posedge clk_i) begin
      if (r_valid_q) begin
         r_hold_q <= mem_r_data_i;
      end
   end

   assign r_data_int = r_valid_q ? mem_r_data_i : r_hold_q;

   generate
      if (W_DATA_W > R_DATA_W) begin : g_write_wider
         logic [LSB_W-1:0]     r_lsb_q;
         logic [MAXDATA_W-1:0] r_shifted;

         // full-width write hits every lane
         assign mem_w_en_o   = {R{w_en_i}};
         assign mem_w_addr_o = w_addr_i[ADDR_W-1:LSB_W];
         assign mem_w_data_o = w_data_i;

         // lane of the pending read, needed when data returns
         always_ff @(posedge clk_i) begin
            if (r_en_i) begin
               r_lsb_q <= r_addr_i[LSB_W-1:0];
            end
         end

         assign mem_r_en_o   = {{(R - 1){1'b0}}, r_en_i} << r_addr_i[LSB_W-1:0];
         assign mem_r_addr_o = r_addr_i[ADDR_W-1:LSB_W];

         assign r_shifted = r_data_int >> (r_lsb_q * R_DATA_W);
         assign r_data_o  = r_shifted[R_DATA_W-1:0];

      end else if (W_DATA_W < R_DATA_W) begin : g_read_wider
         // narrow write goes to one lane, data shifted into its slot
         assign mem_w_en_o   = {{(R - 1){1'b0}}, w_en_i} << w_addr_i[LSB_W-1:0];
         assign mem_w_addr_o = w_addr_i[ADDR_W-1:LSB_W];
         assign mem_w_data_o = {{(R_DATA_W - W_DATA_W){1'b0}}, w_data_i} <<
                               (w_addr_i[LSB_W-1:0] * W_DATA_W);

         // wide read concatenates all lanes
         assign mem_r_en_o   = {R{r_en_i}};
         assign mem_r_addr_o = r_addr_i[ADDR_W-1:LSB_W];
         assign r_data_o     = r_data_int;

      end else begin : g_same_width
         // single lane, addresses pass straight to the RAM
         assign mem_w_en_o   = w_en_i;
         assign mem_w_addr_o = w_addr_i;
         assign mem_w_data_o = w_data_i;

         assign mem_r_en_o   = r_en_i;
         assign mem_r_addr_o = r_addr_i;
         assign r_data_o     = r_data_int;
      end
   endgenerate

endmodule

`default_nettype wire

// File: hw/credit_read_fsm.sv
`default_nettype none

module credit_read_fsm #(
   parameter int CREDITS = 4
) (
   input  wire  clk_i,
   input  wire  rst_n_i,
   input  wire  data_avail_i,
   input  wire  credit_return_i,
   input  wire  flush_i,
   output logic rd_issue_o,
   output logic rd_valid_o,
   output logic ptr_clear_o
);

   afifo_ctrl_pkg::rd_state_t state_q;
   afifo_ctrl_pkg::rd_state_t state_nxt;
   afifo_ctrl_pkg::credit_t   credit_q;
   afifo_ctrl_pkg::credit_t   credit_nxt;
   logic                      rd_valid_q;
   logic                      ptr_clear_q;

   // no new reads while flushing or while pointers are being cleared
   assign rd_issue_o = (state_q != afifo_ctrl_pkg::S_FLUSH) && !ptr_clear_q &&
                       data_avail_i && (credit_q != '0);

   // one credit spent per issue, one gained per returned word
   always_comb begin
      credit_nxt = credit_q;
      if (rd_issue_o) begin
         credit_nxt = credit_nxt - afifo_ctrl_pkg::credit_t'(1);
      end
      if (credit_return_i) begin
         credit_nxt = credit_nxt + afifo_ctrl_pkg::credit_t'(1);
      end
   end

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         afifo_ctrl_pkg::S_IDLE,
         afifo_ctrl_pkg::S_STREAM: begin
            if (flush_i) begin
               state_nxt = afifo_ctrl_pkg::S_FLUSH;
            end else if (rd_issue_o) begin
               state_nxt = afifo_ctrl_pkg::S_STREAM;
            end else begin
               state_nxt = afifo_ctrl_pkg::S_IDLE;
            end
         end
         // in-flight read finishes here, clear follows next cycle
         afifo_ctrl_pkg::S_FLUSH: begin
            state_nxt = afifo_ctrl_pkg::S_IDLE;
         end
         default: begin
            state_nxt = afifo_ctrl_pkg::S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= afifo_ctrl_pkg::S_IDLE;
         credit_q    <= afifo_ctrl_pkg::credit_t'(CREDITS);
         rd_valid_q  <= 1'b0;
         ptr_clear_q <= 1'b0;
      end else begin
         state_q     <= state_nxt;
         credit_q    <= credit_nxt;
         // data is out of the RAM one cycle after the issue
         rd_valid_q  <= rd_issue_o;
         ptr_clear_q <= (state_q == afifo_ctrl_pkg::S_FLUSH);
      end
   end

   assign rd_valid_o  = rd_valid_q;
   assign ptr_clear_o = ptr_clear_q;

endmodule

`default_nettype wire

// File: hw/fifo_ptr_counter.sv
`default_nettype none

module fifo_ptr_counter #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  wire               clk_i,
   input  wire               rst_n_i,
   input  wire               w_en_i,
   input  wire               rd_issue_i,
   input  wire               clear_i,
   output logic [ADDR_W-1:0] wr_ptr_o,
   output logic [ADDR_W-1:0] rd_ptr_o,
   output logic [ADDR_W:0]   level_o,
   output logic              data_avail_o,
   output logic              w_full_o
);

   localparam int MINDATA_W = afifo_cfg_pkg::min_w(W_DATA_W, R_DATA_W);
   // lanes moved per access on each side
   localparam logic [ADDR_W:0] W_STEP = (ADDR_W + 1)'(W_DATA_W / MINDATA_W);
   localparam logic [ADDR_W:0] R_STEP = (ADDR_W + 1)'(R_DATA_W / MINDATA_W);
   localparam logic [ADDR_W:0] DEPTH  = (ADDR_W + 1)'(1 << ADDR_W);

   // pointers carry one wrap bit above the address
   logic [ADDR_W:0] wr_q;
   logic [ADDR_W:0] rd_q;
   logic [ADDR_W:0] wr_nxt;
   logic [ADDR_W:0] rd_nxt;
   logic [ADDR_W:0] level_nxt;
   logic            w_full_q;

   always_comb begin
      if (clear_i) begin
         wr_nxt = '0;
         rd_nxt = '0;
      end else begin
         wr_nxt = w_en_i ? wr_q + W_STEP : wr_q;
         rd_nxt = rd_issue_i ? rd_q + R_STEP : rd_q;
      end
      level_nxt = wr_nxt - rd_nxt;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_q     <= '0;
         rd_q     <= '0;
         w_full_q <= 1'b0;
      end else begin
         wr_q     <= wr_nxt;
         rd_q     <= rd_nxt;
         // no room left for one more narrow word
         w_full_q <= (DEPTH - level_nxt) < W_STEP;
      end
   end

   assign wr_ptr_o     = wr_q[ADDR_W-1:0];
   assign rd_ptr_o     = rd_q[ADDR_W-1:0];
   assign level_o      = wr_q - rd_q;
   assign data_avail_o = level_o >= R_STEP;
   assign w_full_o     = w_full_q;

endmodule

`default_nettype wire

// File: hw/lane_ram.sv
`default_nettype none

module lane_ram #(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6
) (
   input  wire                                 clk_i,
   input  wire [afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W)-1:0] w_en_i,
   input  wire [ADDR_W-$clog2(afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W))-1:0] w_addr_i,
   input  wire [afifo_cfg_pkg::max_w(W_DATA_W, R_DATA_W)-1:0] w_data_i,
   input  wire [afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W)-1:0] r_en_i,
   input  wire [ADDR_W-$clog2(afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W))-1:0] r_addr_i,
   output logic [afifo_cfg_pkg::max_w(W_DATA_W, R_DATA_W)-1:0] r_data_o
);

   localparam int MINDATA_W = afifo_cfg_pkg::min_w(W_DATA_W, R_DATA_W);
   localparam int R         = afifo_cfg_pkg::ratio(W_DATA_W, R_DATA_W);
   localparam int MINADDR_W = ADDR_W - $clog2(R);
   localparam int DEPTH     = 1 << MINADDR_W;

   // one bank per lane, each with its own enables
   generate
      for (genvar b = 0; b < R; b++) begin : g_bank
         logic [MINDATA_W-1:0] mem [DEPTH];
         logic [MINDATA_W-1:0] rd_q;

         always_ff @(posedge clk_i) begin
            if (w_en_i[b]) begin
               mem[w_addr_i] <= w_data_i[b*MINDATA_W +: MINDATA_W];
            end
         end

         // synchronous read, output holds while disabled
         always_ff @(posedge clk_i) begin
            if (r_en_i[b]) begin
               rd_q <= mem[r_addr_i];
            end
         end

         assign r_data_o[b*MINDATA_W +: MINDATA_W] = rd_q;
      end
   endgenerate

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module afifo_tb \
   -Mdir obj_dir \
   -f filelist.f

# the log decides the result, not the exit code of the run
./obj_dir/Vafifo_tb | tee sim.log

if grep -qx "TEST PASS" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: tb/afifo_assertions.sv
`default_nettype none

module afifo_assertions (
   input wire                          clk_i,
   input wire                          rst_n_i,
   input wire afifo_ctrl_pkg::credit_t credit_i,
   input wire                          w_full_i,
   input wire afifo_cfg_pkg::level_t   level_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // the consumer can never hand back more than it was granted
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_i <= afifo_ctrl_pkg::credit_t'(afifo_ctrl_pkg::CREDITS_DEF))
      else $error("credit count above the number granted after reset");

   // narrow step is one lane, so full means every lane is occupied
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_full_i == (level_i == afifo_cfg_pkg::level_t'(1 << afifo_cfg_pkg::ADDR_DEF)))
      else $error("full flag disagrees with the fill level");

endmodule

// fsm side, counter flags tied inactive
bind credit_read_fsm afifo_assertions u_fsm_assertions (
   .clk_i(clk_i), .rst_n_i(rst_n_i), .credit_i(credit_q),
   .w_full_i(1'b0), .level_i(7'd1)
);

// counter side, credit input tied inactive
bind fifo_ptr_counter afifo_assertions u_cnt_assertions (
   .clk_i(clk_i), .rst_n_i(rst_n_i), .credit_i(4'h0),
   .w_full_i(w_full_o), .level_i(level_o)
);

`default_nettype wire

// File: tb/afifo_tb.sv
`default_nettype none

module afifo_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int W_W        = afifo_cfg_pkg::W_DATA_DEF;
   localparam int LANES      = afifo_cfg_pkg::R_DATA_DEF / afifo_cfg_pkg::W_DATA_DEF;
   localparam int FIFO_LANES = 1 << afifo_cfg_pkg::ADDR_DEF;
   localparam int CREDITS    = afifo_ctrl_pkg::CREDITS_DEF;
   localparam int WAIT_LIMIT = 1000;

   logic clk;
   logic rst_n;
   logic w_en;
   logic w_full;
   logic rd_valid;
   logic credit_return;
   logic flush;
   afifo_cfg_pkg::narrow_t w_data;
   afifo_cfg_pkg::wide_t   rd_data;
   afifo_cfg_pkg::wide_t   exp_word;
   afifo_cfg_pkg::level_t  fill_level;

   afifo_cfg_pkg::narrow_t model_q[$];
   int err_count = 0;
   int rx_count = 0;
   int owed = 0;
   int return_mode = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int base;
   int err_before;

   afifo_top u_afifo_top (
      .clk_i(clk), .rst_n_i(rst_n), .w_en_i(w_en), .w_data_i(w_data), .w_full_o(w_full),
      .rd_valid_o(rd_valid), .rd_data_o(rd_data), .credit_return_i(credit_return),
      .flush_i(flush), .fill_level_o(fill_level)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // hard limit on the whole run
   initial begin
      #200000;
      $display("simulation watchdog expired before the tests completed");
      $display("TEST FAIL");
      $finish;
   end

   // oldest LANES bytes of the model, first byte in the lowest lane
   function automatic afifo_cfg_pkg::wide_t pack_expected();
      afifo_cfg_pkg::wide_t w;
      w = '0;
      for (int i = 0; i < LANES; i++) begin
         w[i*W_W +: W_W] = model_q.pop_front();
      end
      return w;
   endfunction

   always @(negedge clk) begin
      if (rst_n && rd_valid) begin
         if (model_q.size() < LANES) begin
            $display("a word was delivered before %0d bytes had been written", LANES);
            err_count++;
         end else begin
            exp_word = pack_expected();
            if (rd_data !== exp_word) begin
               $display("[ERROR] %0t: word %0d expected %h, got %h", $time, rx_count,
                        exp_word, rd_data);
               err_count++;
            end
         end
         rx_count++;
         owed++;
      end
   end

   // consumer hands back one credit per absorbed word
   always @(posedge clk) begin
      if (rst_n && owed > 0 &&
          (return_mode == 1 || (return_mode == 2 && ($urandom % 3) == 0))) begin
         credit_return <= 1'b1;
         owed = owed - 1;
      end else begin
         credit_return <= 1'b0;
      end
   end

   task automatic write_byte(input afifo_cfg_pkg::narrow_t d, input bit honor_full);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (honor_full && w_full && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (honor_full && w_full) begin
         $display("timeout: producer stayed blocked by the full flag");
         err_count++;
      end else begin
         @(posedge clk);
         w_en   <= 1'b1;
         w_data <= d;
         if (honor_full) begin
            model_q.push_back(d);
         end
         @(posedge clk);
         w_en <= 1'b0;
      end
   endtask

   task automatic write_random(input int n);
      for (int i = 0; i < n; i++) begin
         write_byte(afifo_cfg_pkg::narrow_t'($urandom), 1'b1);
      end
   endtask

   task automatic wait_rx(input int target);
      int cycles;
      cycles = 0;
      while (rx_count < target && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (rx_count < target) begin
         $display("timeout: only %0d of %0d words arrived", rx_count, target);
         err_count++;
      end
   endtask

   task automatic wait_credits_back();
      int cycles;
      cycles = 0;
      while (owed > 0 && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (owed > 0) begin
         $display("timeout: %0d credits were never handed back", owed);
         err_count++;
      end
   endtask

   task automatic check_level(input int exp_level, input string what);
      @(negedge clk);
      if (int'(fill_level) != exp_level) begin
         $display("[ERROR] %0t: %s fill level %0d, expected %0d", $time, what,
                  int'(fill_level), exp_level);
         err_count++;
      end
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (err_count == err_before) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, err_count - err_before);
      end
      err_before = err_count;
   endtask

   initial begin
      void'($urandom(32'h91dd1114));
      rst_n = 1'b0;
      w_en = 1'b0;
      w_data = '0;
      credit_return = 1'b0;
      flush = 1'b0;
      err_before = 0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      // lane packing with immediate credit return
      check_level(0, "after reset");
      if (w_full || rd_valid) begin
         $display("[ERROR] %0t: full or valid high after reset", $time);
         err_count++;
      end
      return_mode = 1;
      write_random(16);
      wait_rx(4);
      wait_credits_back();
      close_test("lane packing");

      // credit limit, no credits handed back
      return_mode = 0;
      base = rx_count;
      write_random(32);
      wait_rx(base + CREDITS);
      repeat (50) @(posedge clk);
      if (rx_count != base + CREDITS) begin
         $display("[ERROR] %0t: %0d words without credit, expected %0d", $time,
                  rx_count - base, CREDITS);
         err_count++;
      end
      check_level(32 - CREDITS * LANES, "credit stall");
      close_test("credit limit");

      return_mode = 2;
      wait_rx(base + 8);
      wait_credits_back();
      check_level(0, "after release");
      close_test("credit return");

      // spend every credit, then fill the FIFO with no reads
      return_mode = 0;
      base = rx_count;
      write_random(16);
      wait_rx(base + CREDITS);
      write_random(FIFO_LANES);
      check_level(FIFO_LANES, "filled");
      if (!w_full) begin
         $display("[ERROR] %0t: w_full_o low with the FIFO full", $time);
         err_count++;
      end
      write_byte(8'hee, 1'b0);
      check_level(FIFO_LANES, "after write while full");
      return_mode = 1;
      wait_rx(base + CREDITS + FIFO_LANES / LANES);
      wait_credits_back();
      check_level(0, "drained");
      if (w_full) begin
         $display("[ERROR] %0t: w_full_o still high after draining", $time);
         err_count++;
      end
      close_test("full flag");

      // partial word stored, then flushed
      return_mode = 0;
      write_random(3);
      check_level(3, "before flush");
      @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      repeat (3) @(posedge clk);
      check_level(0, "after flush");
      model_q.delete();
      return_mode = 1;
      base = rx_count;
      write_random(8);
      wait_rx(base + 2);
      wait_credits_back();
      close_test("flush");

      $display("tests %0d, failed %0d, errors %0d, words checked %0d", tests_run,
               tests_failed, err_count, rx_count);
      if (err_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
